/* tb.f */
+incdir+verif
verilog/alu_pkg.sv
verilog/alu_adder.sv
verilog/alu_logic.sv
verilog/alu_shifter.sv
verilog/alu_packed.sv
verilog/alu_result_stage.sv
verilog/alu_top.sv
verif/tb_alu.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator and run it, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps --top-module tb_alu -f tb.f -o tb_alu_sim &&
./obj_dir/tb_alu_sim ||
exit 1

/* verif/tb_alu_vectors.svh */
`ifndef TB_ALU_VECTORS_SVH
`define TB_ALU_VECTORS_SVH

// each row gives name, op, size, a, b, expected result, flags and mask
// flag and mask bits read OF SF ZF AF CF PF from left to right
task automatic load_vectors();
   // add at each width with upper operand bits that the adder ignores
   add_vector("add8_of_af", OP_ADD, SIZE_8, 64'h7f, 64'h01, 64'h80, 6'b110100, 6'b111111);
   add_vector("add8_carry_zero", OP_ADD, SIZE_8, 64'h1234_5678_9abc_deff, 64'h01,
              64'h0, 6'b001111, 6'b111111);
   add_vector("add16_of_zero", OP_ADD, SIZE_16, 64'h8000, 64'h8000, 64'h0, 6'b101011,
              6'b111111);
   add_vector("add16_af", OP_ADD, SIZE_16, 64'h12f8, 64'h0108, 64'h1400, 6'b000101, 6'b111111);
   add_vector("add32_carry_zero", OP_ADD, SIZE_32, 64'hffff_ffff, 64'h01, 64'h0, 6'b001111,
              6'b111111);
   add_vector("add32_of", OP_ADD, SIZE_32, 64'hffff_ffff_7fff_ffff, 64'h01, 64'h8000_0000,
              6'b110101, 6'b111111);

   // upper bits of both operands must not leak into logic results
   add_vector("and8_zext", OP_AND, SIZE_8, 64'hffff_ffff_ffff_fff0, 64'h0f0f_0f0f_0f0f_0ff3,
              64'hf0, 6'b010001, 6'b111011);
   add_vector("and16_zero", OP_AND, SIZE_16, 64'hffff_0000_0000_aaaa, 64'hffff_ffff_ffff_5555,
              64'h0, 6'b001001, 6'b111011);
   add_vector("and32_zext", OP_AND, SIZE_32, 64'hffff_ffff_8000_00ff, 64'hffff_ffff_ffff_0f0f,
              64'h8000_000f, 6'b010001, 6'b111011);
   add_vector("or8_odd", OP_OR, SIZE_8, 64'hff10, 64'h03, 64'h13, 6'b000000, 6'b111011);
   add_vector("or16_sign", OP_OR, SIZE_16, 64'h0000_0001_0003_8000, 64'h07, 64'h8007,
              6'b010000, 6'b111011);
   add_vector("or32_sign", OP_OR, SIZE_32, 64'hffff_0000_8000_0000, 64'h01, 64'h8000_0001,
              6'b010000, 6'b111011);
   add_vector("not8", OP_NOT, SIZE_8, 64'h5a, 64'h0, 64'ha5, 6'b000000, 6'b000000);
   add_vector("not16", OP_NOT, SIZE_16, 64'hff, 64'h0, 64'hff00, 6'b000000, 6'b000000);
   add_vector("not32", OP_NOT, SIZE_32, 64'h1234_5678_0000_ffff, 64'h0, 64'hffff_0000,
              6'b000000, 6'b000000);

   // shift count comes from b[4:0] only
   add_vector("sal_count0", OP_SAL, SIZE_32, 64'hdead_beef_8000_0001, 64'h0, 64'h8000_0001,
              6'b000000, 6'b000000);
   add_vector("sar_count32", OP_SAR, SIZE_32, 64'h8000_0001, 64'h20, 64'h8000_0001,
              6'b000000, 6'b000000);
   add_vector("sal_one_of", OP_SAL, SIZE_32, 64'h4000_0000, 64'h01, 64'h8000_0000,
              6'b110001, 6'b111011);
   add_vector("sar_one", OP_SAR, SIZE_32, 64'h03, 64'h01, 64'h01,
              6'b000010, 6'b111011);
   add_vector("sal_b21", OP_SAL, SIZE_32, 64'hc000_0003, 64'h21, 64'h8000_0006,
              6'b010011, 6'b111011);
   add_vector("sar_four", OP_SAR, SIZE_32, 64'h8000_00f0, 64'h04, 64'hf800_000f,
              6'b010001, 6'b011011);
   add_vector("sal_to_zero", OP_SAL, SIZE_32, 64'h02, 64'h1f, 64'h0, 6'b001011, 6'b011011);

   // packed lanes update no flag
   add_vector("paddw_wrap", OP_PADDW, SIZE_32, 64'h7fff_ffff_0001_8000, 64'h0001_0001_ffff_8000,
              64'h8000_0000_0000_0000, 6'b000000, 6'b000000);
   add_vector("paddd_wrap", OP_PADDD, SIZE_32, 64'h1234_5678_ffff_fffe, 64'h1111_1111_0000_0003,
              64'h2345_6789_0000_0001, 6'b000000, 6'b000000);
   add_vector("pmaxsw", OP_PMAXSW, SIZE_32, 64'h8000_7fff_0005_fffe, 64'h7fff_8000_fffb_ffff,
              64'h7fff_7fff_0005_ffff, 6'b000000, 6'b000000);
   add_vector("pminsw", OP_PMINSW, SIZE_32, 64'h8000_7fff_0005_fffe, 64'h7fff_8000_fffb_ffff,
              64'h8000_8000_fffb_fffe, 6'b000000, 6'b000000);

   add_vector("pass", OP_PASS, SIZE_32, 64'h0123_4567_89ab_cdef, 64'hffff,
              64'h0123_4567_89ab_cdef, 6'b000000, 6'b000000);
   add_vector("unused_code3", 4'd3, SIZE_32, 64'hffff, 64'h01, 64'h0, 6'b000000, 6'b000000);
endtask

`endif

/* verif/tb_alu.sv */
`timescale 1ns/1ps

module tb_alu;

   import alu_pkg::*;

   localparam int CLK_PERIOD = 40;

   typedef struct packed {
      logic [3:0]  op;
      logic [2:0]  size;
      logic [63:0] a;
      logic [63:0] b;
      logic [63:0] exp_result;
      logic [5:0]  exp_flags;
      logic [5:0]  exp_mask;
   } vector_t;

   logic    clk;
   logic    rst_n;
   logic    in_valid;
   alu_op_e alu_op;
   opsize_e opsize;
   word_t   a;
   word_t   b;
   logic    out_valid;
   word_t   result;
   flags_t  eflags;
   flags_t  set_eflags;

   vector_t vectors[$];
   string   names[$];
   int      exp_q[$];       // indices of vectors waiting for their output
   int      vec_n = 0;
   int      seed = 32'h6b5c_d158;
   int      idx;
   vector_t v_chk;
   logic    last_in_valid = 1'b0;  // in_valid as the dut saw it at the last edge

   alu_top i_alu_top (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .alu_op     (alu_op),
      .opsize     (opsize),
      .a          (a),
      .b          (b),
      .out_valid  (out_valid),
      .result     (result),
      .eflags     (eflags),
      .set_eflags (set_eflags)
   );

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected)
         fail_run($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
   endtask

   task automatic add_vector(input string name, input logic [3:0] op, input logic [2:0] size,
                             input logic [63:0] va, input logic [63:0] vb,
                             input logic [63:0] res, input logic [5:0] flg,
                             input logic [5:0] msk);
      vector_t v;
      v = '{op, size, va, vb, res, flg, msk};
      vectors.push_back(v);
      names.push_back(name);
   endtask

   `include "tb_alu_vectors.svh"

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      wait (vec_n > 0);
      repeat (vec_n * 4 + 20) @(posedge clk);  // worst case gap of 2 plus the vector itself
      fail_run("watchdog expired before all vectors were checked");
   end

   // outputs have settled by the falling edge
   always @(negedge clk) begin
      if (rst_n === 1'b1) begin
         check_value("out_valid_timing", 64'(last_in_valid), 64'(out_valid));
         if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
               fail_run("out_valid went high with no operation outstanding");
            end else begin
               idx   = exp_q.pop_front();
               v_chk = vectors[idx];
               check_value({names[idx], " result"}, v_chk.exp_result, result);
               // only flags the operation updates are defined
               check_value({names[idx], " eflags"}, 64'(v_chk.exp_flags & v_chk.exp_mask),
                           64'(eflags & v_chk.exp_mask));
               check_value({names[idx], " set_eflags"}, 64'(v_chk.exp_mask),
                           64'(set_eflags));
            end
         end
      end
      last_in_valid = in_valid;
   end

   initial begin
      int      gap;
      vector_t v;
      rst_n    = 1'b0;
      in_valid = 1'b0;
      alu_op   = OP_PASS;
      opsize   = SIZE_32;
      a        = '0;
      b        = '0;
      load_vectors();
      vec_n = vectors.size();
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_value("set_eflags_after_reset", 64'd0, 64'(set_eflags));

      for (int i = 0; i < vec_n; i++) begin
         gap = $unsigned($random(seed)) % 3;  // 0 to 2 idle cycles
         repeat (gap) begin
            @(posedge clk);
            in_valid <= 1'b0;
         end
         v = vectors[i];
         @(posedge clk);
         in_valid <= 1'b1;
         alu_op   <= alu_op_e'(v.op);
         opsize   <= opsize_e'(v.size);
         a        <= v.a;
         b        <= v.b;
         exp_q.push_back(i);
      end
      @(posedge clk);
      in_valid <= 1'b0;
      repeat (2) @(posedge clk);  // latency is one cycle

      if (exp_q.size() != 0) begin
         fail_run($sformatf("%0d outputs never appeared", exp_q.size()));
      end else begin
         $display("TESTBENCH PASSED");
         $finish;
      end
   end

endmodule

/* verilog/alu_top.sv */
`timescale 1ns/1ps

module alu_top (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             in_valid,
   input  alu_pkg::alu_op_e alu_op,
   input  alu_pkg::opsize_e opsize,
   input  alu_pkg::word_t   a,
   input  alu_pkg::word_t   b,
   output logic             out_valid,
   output alu_pkg::word_t   result,
   output alu_pkg::flags_t  eflags,
   output alu_pkg::flags_t  set_eflags
);

   import alu_pkg::*;

   word_t  add_result;
   word_t  logic_result;
   word_t  shift_result;
   word_t  packed_result;
   flags_t add_flags;
   flags_t add_mask;
   flags_t logic_flags;
   flags_t logic_mask;
   flags_t shift_flags;
   flags_t shift_mask;

   // all units see the operands every cycle, the stage picks one
   alu_adder i_alu_adder (
      .a        (a),
      .b        (b),
      .opsize   (opsize),
      .result   (add_result),
      .flags    (add_flags),
      .set_mask (add_mask)
   );

   alu_logic i_alu_logic (
      .a        (a),
      .b        (b),
      .alu_op   (alu_op),
      .opsize   (opsize),
      .result   (logic_result),
      .flags    (logic_flags),
      .set_mask (logic_mask)
   );

   alu_shifter i_alu_shifter (
      .a        (a),
      .b        (b),
      .alu_op   (alu_op),
      .result   (shift_result),
      .flags    (shift_flags),
      .set_mask (shift_mask)
   );

   alu_packed i_alu_packed (
      .a      (a),
      .b      (b),
      .alu_op (alu_op),
      .result (packed_result)
   );

   alu_result_stage i_alu_result_stage (
      .clk           (clk),
      .rst_n         (rst_n),
      .in_valid      (in_valid),
      .alu_op        (alu_op),
      .a             (a),
      .add_result    (add_result),
      .logic_result  (logic_result),
      .shift_result  (shift_result),
      .packed_result (packed_result),
      .add_flags     (add_flags),
      .add_mask      (add_mask),
      .logic_flags   (logic_flags),
      .logic_mask    (logic_mask),
      .shift_flags   (shift_flags),
      .shift_mask    (shift_mask),
      .out_valid     (out_valid),
      .result        (result),
      .eflags        (eflags),
      .set_eflags    (set_eflags)
   );

endmodule

/* verilog/alu_result_stage.sv */
`timescale 1ns/1ps

module alu_result_stage (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             in_valid,
   input  alu_pkg::alu_op_e alu_op,
   input  alu_pkg::word_t   a,
   input  alu_pkg::word_t   add_result,
   input  alu_pkg::word_t   logic_result,
   input  alu_pkg::word_t   shift_result,
   input  alu_pkg::word_t   packed_result,
   input  alu_pkg::flags_t  add_flags,
   input  alu_pkg::flags_t  add_mask,
   input  alu_pkg::flags_t  logic_flags,
   input  alu_pkg::flags_t  logic_mask,
   input  alu_pkg::flags_t  shift_flags,
   input  alu_pkg::flags_t  shift_mask,
   output logic             out_valid,
   output alu_pkg::word_t   result,
   output alu_pkg::flags_t  eflags,
   output alu_pkg::flags_t  set_eflags
);

   import alu_pkg::*;

   word_t  sel_result;
   flags_t sel_flags;
   flags_t sel_mask;
   flags_t next_flags;

   // pass, packed ops and unused codes update no flag
   always_comb begin
      sel_result = '0;
      sel_flags  = '0;
      sel_mask   = '0;
      case (alu_op)
         OP_PASS: sel_result = a;
         OP_ADD: begin
            sel_result = add_result;
            sel_flags  = add_flags;
            sel_mask   = add_mask;
         end
         OP_AND, OP_OR, OP_NOT: begin
            sel_result = logic_result;
            sel_flags  = logic_flags;
            sel_mask   = logic_mask;
         end
         OP_SAL, OP_SAR: begin
            sel_result = shift_result;
            sel_flags  = shift_flags;
            sel_mask   = shift_mask;
         end
         OP_PADDW, OP_PADDD, OP_PMAXSW, OP_PMINSW: sel_result = packed_result;
         default: ;
      endcase
   end

   // even number of ones in the low byte sets pf
   always_comb begin
      next_flags          = sel_flags;
      next_flags[FLAG_PF] = ~^sel_result[7:0];
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid  <= 1'b0;
         set_eflags <= '0;
      end else begin
         out_valid <= in_valid;
         if (in_valid)
            set_eflags <= sel_mask;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         result <= sel_result;
         eflags <= next_flags;
      end
   end

endmodule

/* verilog/alu_packed.sv */
`timescale 1ns/1ps

module alu_packed (
   input  alu_pkg::word_t   a,
   input  alu_pkg::word_t   b,
   input  alu_pkg::alu_op_e alu_op,
   output alu_pkg::word_t   result
);

   import alu_pkg::*;

   mmx_word_u a_v;
   mmx_word_u b_v;
   mmx_word_u r_v;

   assign a_v = a;
   assign b_v = b;

   // lanes wrap on their own, no carry between lanes
   always_comb begin
      r_v = '0;
      case (alu_op)
         OP_PADDW: begin
            for (int i = 0; i < LANE16_N; i++)
               r_v.w[i] = a_v.w[i] + b_v.w[i];
         end
         OP_PADDD: begin
            for (int i = 0; i < LANE32_N; i++)
               r_v.d[i] = a_v.d[i] + b_v.d[i];
         end
         OP_PMINSW: begin
            for (int i = 0; i < LANE16_N; i++)
               r_v.w[i] = ($signed(a_v.w[i]) < $signed(b_v.w[i])) ? a_v.w[i] : b_v.w[i];
         end
         default: begin  // pmaxsw
            for (int i = 0; i < LANE16_N; i++)
               r_v.w[i] = ($signed(a_v.w[i]) > $signed(b_v.w[i])) ? a_v.w[i] : b_v.w[i];
         end
      endcase
   end

   assign result = r_v;

endmodule

/* verilog/alu_shifter.sv */
`timescale 1ns/1ps

module alu_shifter (
   input  alu_pkg::word_t   a,
   input  alu_pkg::word_t   b,
   input  alu_pkg::alu_op_e alu_op,
   output alu_pkg::word_t   result,
   output alu_pkg::flags_t  flags,
   output alu_pkg::flags_t  set_mask
);

   import alu_pkg::*;

   logic [SHIFT_COUNT_W-1:0] count;
   logic [32:0]              sal_ext;  // carry bit on top
   logic [32:0]              sar_ext;  // carry bit at the bottom
   logic [31:0]              shifted;
   logic                     last_out;
   logic                     count_zero;
   logic                     count_one;

   assign count      = b[SHIFT_COUNT_W-1:0];
   assign count_zero = (count == '0);
   assign count_one  = (count == SHIFT_COUNT_W'(1));

   // one extra bit on each side catches the last bit shifted out
   assign sal_ext = {1'b0, a[31:0]} << count;
   assign sar_ext = $signed({a[31:0], 1'b0}) >>> count;

   always_comb begin
      if (alu_op == OP_SAR) begin
         shifted  = sar_ext[32:1];
         last_out = sar_ext[0];
      end else begin
         shifted  = sal_ext[31:0];
         last_out = sal_ext[32];
      end
   end

   always_comb begin
      flags          = '0;
      flags[FLAG_CF] = last_out;
      flags[FLAG_SF] = shifted[31];
      flags[FLAG_ZF] = (shifted == '0);
      // sar of one always clears of
      if (alu_op == OP_SAL)
         flags[FLAG_OF] = shifted[31] ^ last_out;
   end

   // zero count touches no flag, of only defined for a count of one
   always_comb begin
      set_mask = '0;
      if (!count_zero) begin
         set_mask[FLAG_CF] = 1'b1;
         set_mask[FLAG_SF] = 1'b1;
         set_mask[FLAG_ZF] = 1'b1;
         set_mask[FLAG_PF] = 1'b1;
         set_mask[FLAG_OF] = count_one;
      end
   end

   assign result = {32'd0, shifted};

endmodule

/* verilog/alu_logic.sv */
`timescale 1ns/1ps

module alu_logic (
   input  alu_pkg::word_t   a,
   input  alu_pkg::word_t   b,
   input  alu_pkg::alu_op_e alu_op,
   input  alu_pkg::opsize_e opsize,
   output alu_pkg::word_t   result,
   output alu_pkg::flags_t  flags,
   output alu_pkg::flags_t  set_mask
);

   import alu_pkg::*;

   word_t raw;
   word_t sized;
   int    msb;

   always_comb begin
      case (alu_op)
         OP_AND:  raw = a & b;
         OP_OR:   raw = a | b;
         default: raw = ~a;  // not
      endcase
   end

   assign msb   = size_msb(opsize);
   assign sized = raw & size_mask(opsize);  // zero extended above the size

   // of and cf are always cleared by logic ops
   always_comb begin
      flags          = '0;
      flags[FLAG_SF] = sized[msb];
      flags[FLAG_ZF] = (sized == '0);
   end

   // not leaves every flag alone
   always_comb begin
      set_mask = '0;
      if (alu_op == OP_AND || alu_op == OP_OR) begin
         set_mask          = '1;
         set_mask[FLAG_AF] = 1'b0;  // af undefined after and/or
      end
   end

   assign result = sized;

endmodule

/* verilog/alu_adder.sv */
`timescale 1ns/1ps

module alu_adder (
   input  alu_pkg::word_t   a,
   input  alu_pkg::word_t   b,
   input  alu_pkg::opsize_e opsize,
   output alu_pkg::word_t   result,
   output alu_pkg::flags_t  flags,
   output alu_pkg::flags_t  set_mask
);

   import alu_pkg::*;

   logic [32:0] sum;    // narrower sums are low slices of this one
   logic [32:0] carry;  // carry into each bit position
   word_t       sized;
   int          msb;

   assign sum   = {1'b0, a[31:0]} + {1'b0, b[31:0]};
   assign carry = sum ^ {1'b0, a[31:0]} ^ {1'b0, b[31:0]};

   assign msb   = size_msb(opsize);
   assign sized = {32'd0, sum[31:0]} & size_mask(opsize);

   // a carry into bit k is a carry out of bit k-1
   always_comb begin
      flags          = '0;
      flags[FLAG_CF] = carry[msb+1];
      flags[FLAG_OF] = carry[msb+1] ^ carry[msb];  // carries in and out of the msb differ
      flags[FLAG_SF] = sized[msb];
      flags[FLAG_ZF] = (sized == '0);
      flags[FLAG_AF] = carry[4];                   // out of bit 3
   end

   assign result   = sized;
   assign set_mask = '1;  // add updates every flag

endmodule

/* verilog/alu_pkg.sv */
package alu_pkg;

   localparam int WORD_W = 64;

   typedef logic [WORD_W-1:0] word_t;

   // bit order of the six-flag word
   typedef logic [5:0] flags_t;

   localparam int FLAG_OF = 5;
   localparam int FLAG_SF = 4;
   localparam int FLAG_ZF = 3;
   localparam int FLAG_AF = 2;
   localparam int FLAG_CF = 1;
   localparam int FLAG_PF = 0;

   // codes 3 to 6 and 15 are not used
   typedef enum logic [3:0] {
      OP_PASS   = 4'd0,
      OP_ADD    = 4'd1,
      OP_AND    = 4'd2,
      OP_NOT    = 4'd7,
      OP_OR     = 4'd8,
      OP_PADDW  = 4'd9,
      OP_PADDD  = 4'd10,
      OP_PMAXSW = 4'd11,
      OP_SAL    = 4'd12,
      OP_SAR    = 4'd13,
      OP_PMINSW = 4'd14  // takes the old xchg slot
   } alu_op_e;

   typedef enum logic [2:0] {
      SIZE_8  = 3'd1,
      SIZE_16 = 3'd2,
      SIZE_32 = 3'd4
   } opsize_e;

   localparam int SHIFT_COUNT_W = 5;  // low bits of b only
   localparam int LANE16_N      = 4;
   localparam int LANE32_N      = 2;

   typedef logic signed [15:0] lane16_t;
   typedef logic [31:0]        lane32_t;

   // mmx operand seen as word lanes or dword lanes
   typedef union packed {
      lane16_t [LANE16_N-1:0] w;
      lane32_t [LANE32_N-1:0] d;
   } mmx_word_u;

   // keeps the bits of the operand size, anything unknown is 32 bits
   function automatic word_t size_mask(opsize_e size);
      case (size)
         SIZE_8:  return 64'h0000_0000_0000_00ff;
         SIZE_16: return 64'h0000_0000_0000_ffff;
         default: return 64'h0000_0000_ffff_ffff;
      endcase
   endfunction

   // index of the sign bit at the operand size
   function automatic int size_msb(opsize_e size);
      case (size)
         SIZE_8:  return 7;
         SIZE_16: return 15;
         default: return 31;
      endcase
   endfunction

endpackage
